/* logic/core_defs.svh */
/* core parameters for the ALU pipeline
   widths, register count and instruction field encodings */
`ifndef CORE_DEFS_SVH
`define CORE_DEFS_SVH

`define XLEN        32
`define REG_COUNT   32
`define REG_ADDR_W  5

// major opcodes handled by the core
`define OPC_REG     7'b0110011
`define OPC_IMM     7'b0010011

// funct3 codes for the supported ALU ops
`define F3_ADD      3'b000
`define F3_SLL      3'b001
`define F3_SLT      3'b010
`define F3_XOR      3'b100
`define F3_SRL      3'b101
`define F3_OR       3'b110
`define F3_AND      3'b111

// funct7 patterns where bit 5 selects SUB
`define F7_BASE     7'b0000000
`define F7_ALT      7'b0100000

`endif

/* logic/isaPkg.sv */
/* instruction set types
   instruction word views and ALU operation codes */
`default_nettype none
`include "core_defs.svh"

package isaPkg;

	// register-register format
	typedef struct packed {
		logic [6:0] funct7;
		logic [`REG_ADDR_W-1:0] rs2;
		logic [`REG_ADDR_W-1:0] rs1;
		logic [2:0] funct3;
		logic [`REG_ADDR_W-1:0] rd;
		logic [6:0] opcode;
	} rType;

	// register-immediate format
	typedef struct packed {
		logic [11:0] imm12;
		logic [`REG_ADDR_W-1:0] rs1;
		logic [2:0] funct3;
		logic [`REG_ADDR_W-1:0] rd;
		logic [6:0] opcode;
	} iType;

	// same 32 bits read as either format
	typedef union packed {
		rType rView;
		iType iView;
	} instrWord;

	// operations the ALU knows
	typedef enum logic [3:0] {
		ADD,
		SUB,
		AND,
		OR,
		XOR,
		SLT,
		SLL,
		SRL
	} aluOp;

endpackage : isaPkg

`default_nettype wire

/* logic/stagePkg.sv */
/* pipeline stage bundles
   contents of each stage register and of the retire port */
`default_nettype none
`include "core_defs.svh"

package stagePkg;

	// fetched word waiting for decode
	typedef struct packed {
		isaPkg::instrWord instr;
		logic valid;
	} decodeBundle;

	// decoded instruction with its operands
	typedef struct packed {
		logic valid;
		logic regWrite;
		// second operand comes from imm
		logic useImm;
		isaPkg::aluOp op;
		logic [`REG_ADDR_W-1:0] rs1;
		logic [`REG_ADDR_W-1:0] rs2;
		logic [`REG_ADDR_W-1:0] rd;
		// values read in decode that forwarding may replace
		logic [`XLEN-1:0] rs1Val;
		logic [`XLEN-1:0] rs2Val;
		// sign-extended immediate
		logic [`XLEN-1:0] imm;
	} execBundle;

	// computed result heading for writeback
	typedef struct packed {
		logic valid;
		logic regWrite;
		logic [`REG_ADDR_W-1:0] rd;
		logic [`XLEN-1:0] value;
	} resultBundle;

endpackage : stagePkg

`default_nettype wire

/* logic/stageRegs.sv */
/* pipeline stage registers
   each has active-low enable, synchronous clear and async reset */
`default_nettype none

// IF/ID register
module fetchDecodeReg (
	input logic clk,
	input logic reset,
	input logic en,
	input logic clear,
	input stagePkg::decodeBundle d,
	output stagePkg::decodeBundle q
);

	always_ff @(posedge clk or negedge reset) begin
		if (!reset || clear) begin
			q <= '0;
		end else if (!en) begin
			q <= d;
		end
	end

endmodule : fetchDecodeReg

// ID/EX register
module decodeExecReg (
	input logic clk,
	input logic reset,
	input logic en,
	input logic clear,
	input stagePkg::execBundle d,
	output stagePkg::execBundle q
);

	always_ff @(posedge clk or negedge reset) begin
		if (!reset || clear) begin
			q <= '0;
		end else if (!en) begin
			q <= d;
		end
	end

endmodule : decodeExecReg

// EX/MEM register
module execMemReg (
	input logic clk,
	input logic reset,
	input logic en,
	input logic clear,
	input stagePkg::resultBundle d,
	output stagePkg::resultBundle q
);

	always_ff @(posedge clk or negedge reset) begin
		if (!reset || clear) begin
			q <= '0;
		end else if (!en) begin
			q <= d;
		end
	end

endmodule : execMemReg

// MEM/WB register
module memWriteReg (
	input logic clk,
	input logic reset,
	input logic en,
	input logic clear,
	input stagePkg::resultBundle d,
	output stagePkg::resultBundle q
);

	always_ff @(posedge clk or negedge reset) begin
		if (!reset || clear) begin
			q <= '0;
		end else if (!en) begin
			q <= d;
		end
	end

endmodule : memWriteReg

`default_nettype wire

/* logic/instrDecoder.sv */
/* instruction decoder
   builds the execute bundle from a fetched word and register reads */
`default_nettype none
`include "core_defs.svh"

module instrDecoder (
	input stagePkg::decodeBundle fetched,
	input logic [`XLEN-1:0] rs1Val,
	input logic [`XLEN-1:0] rs2Val,
	output stagePkg::execBundle decoded
);

	isaPkg::instrWord word;
	isaPkg::aluOp op;
	logic isReg;
	logic isImm;
	logic isShift;
	logic f7Base;
	logic f7Alt;
	logic f3Valid;
	logic regOk;
	logic immOk;
	logic known;

	assign word = fetched.instr;
	assign isReg = (word.rView.opcode == `OPC_REG);
	assign isImm = (word.iView.opcode == `OPC_IMM);
	assign isShift = (word.rView.funct3 == `F3_SLL) || (word.rView.funct3 == `F3_SRL);
	assign f7Base = (word.rView.funct7 == `F7_BASE);
	assign f7Alt = (word.rView.funct7 == `F7_ALT);

	// funct3 picks the op for both formats
	always_comb begin
		f3Valid = 1'b1;
		case (word.rView.funct3)
			// SUB only exists in R-type
			`F3_ADD: op = (isReg && f7Alt) ? isaPkg::SUB : isaPkg::ADD;
			`F3_SLL: op = isaPkg::SLL;
			`F3_SLT: op = isaPkg::SLT;
			`F3_XOR: op = isaPkg::XOR;
			`F3_SRL: op = isaPkg::SRL;
			`F3_OR:  op = isaPkg::OR;
			`F3_AND: op = isaPkg::AND;
			default: begin
				// SLTU and SLTIU are not supported
				op = isaPkg::ADD;
				f3Valid = 1'b0;
			end
		endcase
	end

	// R-type needs a clean funct7 unless it is SUB
	assign regOk = isReg && (f7Base || (f7Alt && word.rView.funct3 == `F3_ADD));
	// shift immediates need a clean upper field so SRAI is rejected
	assign immOk = isImm && (!isShift || word.iView.imm12[11:5] == `F7_BASE);
	assign known = f3Valid && (regOk || immOk);

	always_comb begin
		// unknown encodings become bubbles
		decoded.valid = fetched.valid && known;
		decoded.regWrite = fetched.valid && known;
		decoded.useImm = isImm;
		decoded.op = op;
		decoded.rs1 = word.rView.rs1;
		decoded.rs2 = word.rView.rs2;
		decoded.rd = word.rView.rd;
		decoded.rs1Val = rs1Val;
		decoded.rs2Val = rs2Val;
		decoded.imm = {{(`XLEN-12){word.iView.imm12[11]}}, word.iView.imm12};
	end

endmodule : instrDecoder

`default_nettype wire

/* logic/regFile.sv */
/* integer register file
   two read ports with write-through, x0 reads as zero */
`default_nettype none
`include "core_defs.svh"

module regFile (
	input logic clk,
	input logic reset,
	input logic [`REG_ADDR_W-1:0] rs1,
	input logic [`REG_ADDR_W-1:0] rs2,
	output logic [`XLEN-1:0] rs1Val,
	output logic [`XLEN-1:0] rs2Val,
	input stagePkg::resultBundle wb
);

	logic [`XLEN-1:0] regs [`REG_COUNT];
	logic wrEn;

	// x0 is never written
	assign wrEn = wb.valid && wb.regWrite && (wb.rd != '0);

	always_ff @(posedge clk or negedge reset) begin
		if (!reset) begin
			for (int i = 0; i < `REG_COUNT; i++) begin
				regs[i] <= '0;
			end
		end else if (wrEn) begin
			regs[wb.rd] <= wb.value;
		end
	end

	// same-cycle writeback bypasses the array
	assign rs1Val = (rs1 == '0) ? '0 :
		(wrEn && wb.rd == rs1) ? wb.value : regs[rs1];
	assign rs2Val = (rs2 == '0) ? '0 :
		(wrEn && wb.rd == rs2) ? wb.value : regs[rs2];

endmodule : regFile

`default_nettype wire

/* logic/executeUnit.sv */
/* execute stage
   operand forwarding from the later stages and the ALU */
`default_nettype none
`include "core_defs.svh"

module executeUnit (
	input stagePkg::execBundle exec,
	input stagePkg::resultBundle memFwd,
	input stagePkg::resultBundle wbFwd,
	output stagePkg::resultBundle result
);

	logic [`XLEN-1:0] srcA;
	logic [`XLEN-1:0] srcB;
	logic [`XLEN-1:0] opB;
	logic [4:0] shamt;
	logic [`XLEN-1:0] aluOut;

	// a later stage supplies src when it writes that register
	function automatic logic fwdHit(stagePkg::resultBundle fwd, logic [`REG_ADDR_W-1:0] src);
		return fwd.valid && fwd.regWrite && (fwd.rd != '0) && (fwd.rd == src);
	endfunction

	// youngest producer wins
	function automatic logic [`XLEN-1:0] pickOperand(
		logic [`REG_ADDR_W-1:0] src,
		logic [`XLEN-1:0] readVal,
		stagePkg::resultBundle memSide,
		stagePkg::resultBundle wbSide
	);
		if (fwdHit(memSide, src)) begin
			return memSide.value;
		end
		if (fwdHit(wbSide, src)) begin
			return wbSide.value;
		end
		return readVal;
	endfunction

	assign srcA = pickOperand(exec.rs1, exec.rs1Val, memFwd, wbFwd);
	assign srcB = pickOperand(exec.rs2, exec.rs2Val, memFwd, wbFwd);
	assign opB = exec.useImm ? exec.imm : srcB;
	// shift amount from low 5 bits
	assign shamt = opB[4:0];

	always_comb begin
		case (exec.op)
			isaPkg::ADD: aluOut = srcA + opB;
			isaPkg::SUB: aluOut = srcA - opB;
			isaPkg::AND: aluOut = srcA & opB;
			isaPkg::OR:  aluOut = srcA | opB;
			isaPkg::XOR: aluOut = srcA ^ opB;
			// signed compare
			isaPkg::SLT: aluOut = {{(`XLEN-1){1'b0}}, $signed(srcA) < $signed(opB)};
			isaPkg::SLL: aluOut = srcA << shamt;
			isaPkg::SRL: aluOut = srcA >> shamt;
			default:     aluOut = '0;
		endcase
	end

	assign result.valid = exec.valid;
	assign result.regWrite = exec.regWrite;
	assign result.rd = exec.rd;
	assign result.value = aluOut;

endmodule : executeUnit

`default_nettype wire

/* logic/aluPipeline.sv */
/* five-stage ALU pipeline top level
   joins stage registers, decode, register file and execute */
`default_nettype none
`include "core_defs.svh"

module aluPipeline (
	input logic clk,
	input logic reset,
	input isaPkg::instrWord instr,
	input logic instrValid,
	input logic hold,
	input logic flush,
	output stagePkg::resultBundle retire
);

	stagePkg::decodeBundle fetchIn;
	stagePkg::decodeBundle fetched;
	stagePkg::execBundle decoded;
	stagePkg::execBundle execStage;
	stagePkg::resultBundle execResult;
	stagePkg::resultBundle memStage;
	stagePkg::resultBundle wbStage;
	logic [`XLEN-1:0] rs1Val;
	logic [`XLEN-1:0] rs2Val;

	assign fetchIn.instr = instr;
	assign fetchIn.valid = instrValid;

	// hold freezes every stage, flush empties every stage
	fetchDecodeReg ifId (
		.clk(clk), .reset(reset), .en(hold), .clear(flush), .d(fetchIn), .q(fetched)
	);

	// read addresses straight from the fetched word
	regFile rf (
		.clk(clk), .reset(reset),
		.rs1(fetched.instr.rView.rs1), .rs2(fetched.instr.rView.rs2),
		.rs1Val(rs1Val), .rs2Val(rs2Val), .wb(retire)
	);

	instrDecoder dec (
		.fetched(fetched), .rs1Val(rs1Val), .rs2Val(rs2Val), .decoded(decoded)
	);

	decodeExecReg idEx (
		.clk(clk), .reset(reset), .en(hold), .clear(flush), .d(decoded), .q(execStage)
	);

	executeUnit exu (
		.exec(execStage), .memFwd(memStage), .wbFwd(wbStage), .result(execResult)
	);

	execMemReg exMem (
		.clk(clk), .reset(reset), .en(hold), .clear(flush), .d(execResult), .q(memStage)
	);

	memWriteReg memWb (
		.clk(clk), .reset(reset), .en(hold), .clear(flush), .d(memStage), .q(wbStage)
	);

	// a held writeback sits still, so it strobes once on the advancing edge
	always_comb begin
		retire = wbStage;
		retire.valid = wbStage.valid && !hold;
	end

endmodule : aluPipeline

`default_nettype wire

/* testbench/aluPipelineTb.sv */
/* testbench for the ALU pipeline
   replays the case file and checks the retire stream in order */
`default_nettype none

module aluPipelineTb;
	timeunit 1ns;
	timeprecision 100ps;

	// bound on each wait for a retirement
	localparam int RETIRE_WAIT = 20;
	// twice the pipeline depth drains everything
	localparam int DRAIN_CYCLES = 8;

	logic clk;
	logic reset;
	isaPkg::instrWord instr;
	logic instrValid;
	logic hold;
	logic flush;
	stagePkg::resultBundle retire;

	// retire strobes not yet matched, oldest first
	stagePkg::resultBundle retired[$];

	aluPipeline dut (
		.clk(clk), .reset(reset), .instr(instr), .instrValid(instrValid),
		.hold(hold), .flush(flush), .retire(retire)
	);

	always #5 clk = ~clk;

	// a retirement counts at the edge that writes it back
	always @(posedge clk) begin
		if (retire.valid === 1'b1) begin
			retired.push_back(retire);
		end
	end

	task automatic stopRun(input string why);
		$display("%s", why);
		$display("Test failed");
		$fatal(1, "simulation stopped at the first error");
	endtask

	// compare a retired bundle with the expected one
	task automatic checkRetire(input stagePkg::resultBundle got,
		input stagePkg::resultBundle want);
		if (got.rd !== want.rd) begin
			stopRun($sformatf("CHECK FAILED at %0t: retire.rd got %0d expected %0d",
				$time, got.rd, want.rd));
		end else if (got.regWrite !== want.regWrite) begin
			stopRun($sformatf("CHECK FAILED at %0t: retire.regWrite got %b expected %b",
				$time, got.regWrite, want.regWrite));
		end else if (got.value !== want.value) begin
			stopRun($sformatf("CHECK FAILED at %0t: retire.value got %h expected %h",
				$time, got.value, want.value));
		end
	endtask

	// bounded wait for the next retirement from the monitor
	task automatic waitRetire(output stagePkg::resultBundle got);
		int cycles;
		cycles = 0;
		while (retired.size() == 0 && cycles < RETIRE_WAIT) begin
			@(negedge clk);
			cycles++;
		end
		if (retired.size() == 0) begin
			stopRun($sformatf("no instruction retired within %0d cycles, at %0t",
				RETIRE_WAIT, $time));
		end else begin
			got = retired.pop_front();
		end
	endtask

	// valid for one cycle so back-to-back issues stay valid across the edge
	task automatic issue(input isaPkg::instrWord word);
		instr = word;
		instrValid = 1'b1;
		@(negedge clk);
		instrValid = 1'b0;
	endtask

	task automatic holdFor(input int cycles);
		hold = 1'b1;
		repeat (cycles) @(negedge clk);
		hold = 1'b0;
	endtask

	task automatic flushOnce();
		flush = 1'b1;
		@(negedge clk);
		flush = 1'b0;
	endtask

	initial begin
		int fd;
		int n;
		int holdCycles;
		logic [7:0] kind;
		logic [8*120-1:0] rest;
		logic [31:0] word;
		logic [4:0] rd;
		logic [31:0] value;
		logic done;
		stagePkg::resultBundle want;
		stagePkg::resultBundle got;

		clk = 1'b0;
		reset = 1'b0;
		instr = '0;
		instrValid = 1'b0;
		hold = 1'b0;
		flush = 1'b0;
		fd = $fopen("testbench/pipe_cases.txt", "r");
		if (fd == 0) begin
			stopRun("could not open the case file testbench/pipe_cases.txt");
		end
		repeat (2) @(negedge clk);
		reset = 1'b1;
		// nothing may retire out of reset
		repeat (2) @(negedge clk);
		if (retired.size() != 0) begin
			stopRun("a retire strobe appeared during or right after reset");
		end
		done = 1'b0;
		while (!done) begin
			n = $fscanf(fd, "%s", kind);
			if (n != 1) begin
				done = 1'b1;
			end else if (kind == "#") begin
				n = $fgets(rest, fd);
			end else if (kind == "I") begin
				n = $fscanf(fd, "%h", word);
				issue(word);
			end else if (kind == "H") begin
				n = $fscanf(fd, "%d", holdCycles);
				holdFor(holdCycles);
			end else if (kind == "F") begin
				flushOnce();
			end else if (kind == "E") begin
				n = $fscanf(fd, "%h %h", rd, value);
				want.valid = 1'b1;
				want.regWrite = 1'b1;
				want.rd = rd;
				want.value = value;
				waitRetire(got);
				checkRetire(got, want);
			end else begin
				stopRun($sformatf("unknown record kind '%c' in the case file", kind));
			end
		end
		$fclose(fd);
		// flushed and unknown instructions must not show up late
		repeat (DRAIN_CYCLES) @(negedge clk);
		if (retired.size() != 0) begin
			stopRun($sformatf("%0d unexpected retirements left at the end", retired.size()));
		end else begin
			$display("Test passed");
			$finish;
		end
	end

endmodule : aluPipelineTb

`default_nettype wire

/* testbench/pipe_cases.txt */
# kinds: I word = issue, H n = hold n cycles, F = flush, E rd value = expected retire
# word, rd and value in hex
# immediates from zero: addi x1 x2, andi, ori, xori, slti
I 06400093
I ffd00113
I ff017193
I 0f00e213
I fff0c293
I ffe12313
E 1 00000064
E 2 fffffffd
E 3 fffffff0
E 4 000000f4
E 5 ffffff9b
E 6 00000001
# register ops with dependences at distance one, two and three
I 002083b3
I 40138433
I 0043f4b3
I 0083e533
I 009545b3
I 00942633
I 00c096b3
I 0065d733
E 7 00000061
E 8 fffffffd
E 9 00000060
E a fffffffd
E b ffffff9d
E c 00000001
E d 000000c8
E e 7fffffce
# write to x0, unknown opcode, then read x0
I 00508013
I 0000007f
I 001007b3
E 0 00000069
E f 00000064
# hold inside a dependent chain
I 00108813
H 3
I 010808b3
H 2
I 41088933
E 10 00000065
E 11 000000ca
E 12 00000065
# flush kills addi x1 and addi x2, add sees the old values
I 00700093
I 00900113
F
I 002089b3
E 13 00000061

/* list.f */
+incdir+logic
logic/isaPkg.sv
logic/stagePkg.sv
logic/stageRegs.sv
logic/instrDecoder.sv
logic/regFile.sv
logic/executeUnit.sv
logic/aluPipeline.sv
testbench/aluPipelineTb.sv

/* run.sh */
#!/bin/sh
# build and run the ALU pipeline testbench with Verilator
set -e
cd "$(dirname "$0")"
rm -f sim.log
verilator --binary --timing -f list.f --top-module aluPipelineTb --Mdir obj_dir -o simv
# the log decides the result, so a nonzero exit here must not stop the script
./obj_dir/simv > sim.log 2>&1 || true
cat sim.log
if grep -q "Test failed" sim.log; then
	echo "simulation reported a failure"
	exit 1
fi
echo "simulation finished without failures"
